/* design/board_pkg.sv */
package board_pkg;

    // Game video
    localparam int color_w = 4;               // Bits per game color channel
    typedef logic [color_w-1:0] color_t;
    typedef logic [7:0]         rgb8_t;        // Output channel

    // Joystick buses
    localparam int joy_board_w = 16;
    typedef logic [joy_board_w-1:0] joy_board_t;

    localparam int joy_game_w = 10;
    typedef logic [joy_game_w-1:0] joy_game_t;

    // OSD status word and the settings it holds
    localparam int status_w = 32;
    typedef logic [status_w-1:0] status_t;

    localparam int st_rotate_bit = 2;
    localparam int st_flip_bit   = 3;
    localparam int st_pause_bit  = 4;
    localparam int st_test_bit   = 5;

    // Game side inputs idle high
    localparam bit active_low_inputs = 1'b1;

    // Game reset stretch, in clk_sys cycles after the last trigger
    localparam int game_rst_cycles = 16;
    typedef logic [4:0] rst_cnt_t;

    // Graphics layer enables
    localparam int gfx_layers = 4;
    typedef logic [gfx_layers-1:0] gfx_t;

endpackage

/* design/board_settings.sv */
`timescale 1ns/1ps

module board_settings (
    input  logic                clk_sys,
    input  logic                rst,
    input  board_pkg::status_t  status,
    input  logic                game_pause,
    board_settings_if.src       settings
);
    import board_pkg::*;

    logic pause_req;

    // Either the OSD or the player can hold the game
    assign pause_req = status[st_pause_bit] | game_pause;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            settings.rot_control <= 1'b0;
            settings.dip_flip    <= 1'b0;
            settings.dip_test    <= 1'b0;
            settings.dip_pause   <= 1'b1;    // Running
        end else begin
            settings.rot_control <= status[st_rotate_bit];
            settings.dip_flip    <= status[st_flip_bit];
            settings.dip_test    <= status[st_test_bit];
            settings.dip_pause   <= ~pause_req;
        end
    end

    // A pause held by the player reaches the game within a cycle
    a_pause_reaches_dip : assert property (
        @(posedge clk_sys) disable iff (rst)
        game_pause && $past(game_pause) |-> !settings.dip_pause
    ) else $error("dip_pause high while game_pause held");

endmodule

/* design/board_settings_if.sv */
`timescale 1ns/1ps

interface board_settings_if;

    logic rot_control;   // Rotate joystick directions
    logic dip_flip;      // Screen flip, a change restarts the game
    logic dip_pause;     // Active low
    logic dip_test;

    modport src (
        output rot_control,
        output dip_flip,
        output dip_pause,
        output dip_test
    );

    modport snk (
        input rot_control,
        input dip_flip,
        input dip_pause,
        input dip_test
    );

endinterface

/* design/board_top.sv */
`timescale 1ns/1ps

module board_top (
    input  logic                  clk_sys,
    input  logic                  rst,
    // Reset triggers
    input  logic                  downloading,
    input  logic                  rst_req,
    output logic                  game_rst,
    // OSD settings
    input  board_pkg::status_t    status,
    output logic                  dip_flip,
    output logic                  dip_pause,
    output logic                  dip_test,
    // Player inputs
    input  board_pkg::joy_board_t board_joystick1,
    input  board_pkg::joy_board_t board_joystick2,
    input  logic [1:0]            key_coin,
    input  logic [1:0]            key_start,
    input  logic                  key_pause,
    input  logic                  key_reset,
    input  logic                  key_service,
    input  board_pkg::gfx_t       key_gfx,
    output board_pkg::joy_game_t  game_joystick1,
    output board_pkg::joy_game_t  game_joystick2,
    output logic [1:0]            game_coin,
    output logic [1:0]            game_start,
    output logic                  game_service,
    output logic                  game_pause,
    output board_pkg::gfx_t       gfx_en,
    // Video
    input  logic                  pxl_cen,
    input  board_pkg::color_t     game_r,
    input  board_pkg::color_t     game_g,
    input  board_pkg::color_t     game_b,
    input  logic                  lhbl,
    input  logic                  lvbl,
    input  logic                  hs,
    input  logic                  vs,
    output board_pkg::rgb8_t      vid_r,
    output board_pkg::rgb8_t      vid_g,
    output board_pkg::rgb8_t      vid_b,
    output logic                  vid_hs,
    output logic                  vid_vs,
    output logic                  vid_de
);

    logic soft_rst;

    board_settings_if settings ();

    assign dip_flip  = settings.dip_flip;
    assign dip_pause = settings.dip_pause;
    assign dip_test  = settings.dip_test;

    board_settings u_settings (
        .clk_sys    ( clk_sys    ),
        .rst        ( rst        ),
        .status     ( status     ),
        .game_pause ( game_pause ),
        .settings   ( settings   )
    );

    game_reset_seq u_reset (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .rst_req     ( rst_req     ),
        .soft_rst    ( soft_rst    ),
        .settings    ( settings    ),
        .game_rst    ( game_rst    )
    );

    player_input_map u_inputs (
        .clk_sys         ( clk_sys         ),
        .rst             ( rst             ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .key_coin        ( key_coin        ),
        .key_start       ( key_start       ),
        .key_pause       ( key_pause       ),
        .key_reset       ( key_reset       ),
        .key_service     ( key_service     ),
        .key_gfx         ( key_gfx         ),
        .settings        ( settings        ),
        .game_joystick1  ( game_joystick1  ),
        .game_joystick2  ( game_joystick2  ),
        .game_coin       ( game_coin       ),
        .game_start      ( game_start      ),
        .game_service    ( game_service    ),
        .game_pause      ( game_pause      ),
        .soft_rst        ( soft_rst        ),
        .gfx_en          ( gfx_en          )
    );

    video_color_out u_video (
        .clk_sys ( clk_sys ),
        .rst     ( rst     ),
        .pxl_cen ( pxl_cen ),
        .game_r  ( game_r  ),
        .game_g  ( game_g  ),
        .game_b  ( game_b  ),
        .lhbl    ( lhbl    ),
        .lvbl    ( lvbl    ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .vid_r   ( vid_r   ),
        .vid_g   ( vid_g   ),
        .vid_b   ( vid_b   ),
        .vid_hs  ( vid_hs  ),
        .vid_vs  ( vid_vs  ),
        .vid_de  ( vid_de  )
    );

endmodule

/* design/game_reset_seq.sv */
`timescale 1ns/1ps

module game_reset_seq (
    input  logic          clk_sys,
    input  logic          rst,
    input  logic          downloading,   // ROM load in progress
    input  logic          rst_req,
    input  logic          soft_rst,      // One cycle pulse from the keyboard
    board_settings_if.snk settings,
    output logic          game_rst
);
    import board_pkg::*;

    logic     last_flip;
    logic     flip_change;
    logic     trigger;
    rst_cnt_t rst_cnt;

    assign flip_change = settings.dip_flip != last_flip;

    // Any of these restarts the stretch
    assign trigger = rst | downloading | rst_req | soft_rst | flip_change;

    always_ff @(posedge clk_sys) begin
        last_flip <= settings.dip_flip;
    end

    // Counter starts at one so the final count matches the stretch length
    always_ff @(posedge clk_sys) begin
        if (trigger) begin
            rst_cnt  <= rst_cnt_t'(1);
            game_rst <= 1'b1;
        end else if (rst_cnt != rst_cnt_t'(game_rst_cycles)) begin
            rst_cnt  <= rst_cnt + rst_cnt_t'(1);
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;       // Stretch done, counter parks here
        end
    end

    // Board reset always reaches the game
    a_rst_to_game_rst : assert property (
        @(posedge clk_sys) rst |=> game_rst
    ) else $error("game_rst low after rst");

endmodule

/* design/player_input_map.sv */
`timescale 1ns/1ps

module player_input_map #(
    parameter int three_buttons = 0
) (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  board_pkg::joy_board_t board_joystick1,
    input  board_pkg::joy_board_t board_joystick2,
    input  logic [1:0]            key_coin,
    input  logic [1:0]            key_start,
    input  logic                  key_pause,
    input  logic                  key_reset,
    input  logic                  key_service,
    input  board_pkg::gfx_t       key_gfx,
    board_settings_if.snk         settings,
    output board_pkg::joy_game_t  game_joystick1,
    output board_pkg::joy_game_t  game_joystick2,
    output logic [1:0]            game_coin,
    output logic [1:0]            game_start,
    output logic                  game_service,
    output logic                  game_pause,
    output logic                  soft_rst,
    output board_pkg::gfx_t       gfx_en
);
    import board_pkg::*;

    // A third fire button pushes the system bits up by one
    localparam int start1_bit = 6 + three_buttons;
    localparam int start2_bit = 7 + three_buttons;
    localparam int coin_bit   = 8 + three_buttons;
    localparam int pause_bit  = 9 + three_buttons;

    localparam joy_game_t  joy_mask  = {joy_game_w{active_low_inputs}};
    localparam logic [1:0] pair_mask = {2{active_low_inputs}};

    joy_board_t joy1_sync;
    joy_board_t joy2_sync;
    logic       joy_pause;
    logic       last_pause;
    logic       last_joypause;
    logic       last_reset;
    gfx_t       last_gfx;
    gfx_t       gfx_rise;
    logic [1:0] start_any;
    logic [1:0] coin_any;

    // Swaps the direction bits for a rotated screen
    function automatic joy_game_t apply_rotation(input joy_game_t joy, input logic rot);
        joy_game_t rotated;
        rotated = {joy[9:4], joy[0], joy[1], joy[3], joy[2]};
        return rot ? rotated : joy;
    endfunction

    // Input register, boards drive these asynchronously
    always_ff @(posedge clk_sys) begin
        joy1_sync <= board_joystick1;
        joy2_sync <= board_joystick2;
    end

    assign joy_pause = joy1_sync[pause_bit] | joy2_sync[pause_bit];
    assign gfx_rise  = key_gfx & ~last_gfx;

    assign start_any = {joy1_sync[start2_bit], joy1_sync[start1_bit]}
                     | {joy2_sync[start2_bit], joy2_sync[start1_bit]}
                     | key_start;
    assign coin_any  = {joy2_sync[coin_bit], joy1_sync[coin_bit]} | key_coin;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joystick1 <= joy_mask;      // Idle in game polarity
            game_joystick2 <= joy_mask;
            game_coin      <= pair_mask;
            game_start     <= pair_mask;
            game_service   <= active_low_inputs;
        end else begin
            game_joystick1 <= apply_rotation(joy1_sync[joy_game_w-1:0],
                                             settings.rot_control) ^ joy_mask;
            game_joystick2 <= apply_rotation(joy2_sync[joy_game_w-1:0],
                                             settings.rot_control) ^ joy_mask;
            game_coin      <= coin_any ^ pair_mask;
            game_start     <= start_any ^ pair_mask;
            game_service   <= key_service ^ active_low_inputs;
        end
    end

    // Edge detectors for the toggle keys
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_pause    <= 1'b0;
            last_joypause <= 1'b0;
            last_reset    <= 1'b0;
            last_gfx      <= '0;
            game_pause    <= 1'b0;
            soft_rst      <= 1'b0;
            gfx_en        <= '1;     // All layers on
        end else begin
            last_pause    <= key_pause;
            last_joypause <= joy_pause;
            last_reset    <= key_reset;
            last_gfx      <= key_gfx;
            soft_rst      <= key_reset && !last_reset;
            gfx_en        <= gfx_en ^ gfx_rise;
            if ((key_pause && !last_pause) || (joy_pause && !last_joypause)) begin
                game_pause <= ~game_pause;
            end
        end
    end

    // The game reset sequencer expects a single pulse per key press
    a_soft_rst_pulse : assert property (
        @(posedge clk_sys) disable iff (rst)
        soft_rst |=> !soft_rst
    ) else $error("soft_rst held for two cycles");

endmodule

/* design/video_color_out.sv */
`timescale 1ns/1ps

module video_color_out (
    input  logic              clk_sys,
    input  logic              rst,
    input  logic              pxl_cen,     // Pixel clock enable
    input  board_pkg::color_t game_r,
    input  board_pkg::color_t game_g,
    input  board_pkg::color_t game_b,
    input  logic              lhbl,        // Low during horizontal blank
    input  logic              lvbl,        // Low during vertical blank
    input  logic              hs,
    input  logic              vs,
    output board_pkg::rgb8_t  vid_r,
    output board_pkg::rgb8_t  vid_g,
    output board_pkg::rgb8_t  vid_b,
    output logic              vid_hs,
    output logic              vid_vs,
    output logic              vid_de
);
    import board_pkg::*;

    // Repeats the channel from its MSB down so full scale stays full scale
    function automatic rgb8_t extend8(input color_t c);
        rgb8_t e;
        for (int i = 0; i < 8; i++) begin
            e[7-i] = c[color_w - 1 - (i % color_w)];
        end
        return e;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            vid_r <= extend8(game_r);
            vid_g <= extend8(game_g);
            vid_b <= extend8(game_b);
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            vid_hs <= 1'b0;
            vid_vs <= 1'b0;
            vid_de <= 1'b0;
        end else if (pxl_cen) begin
            vid_hs <= hs;
            vid_vs <= vs;
            vid_de <= lhbl & lvbl;   // Visible area only
        end
    end

endmodule

/* list.f */
design/board_pkg.sv
design/board_settings_if.sv
design/board_settings.sv
design/game_reset_seq.sv
design/player_input_map.sv
design/video_color_out.sv
design/board_top.sv
tb/board_tb.sv

/* run.sh */
#!/bin/bash
# Builds and runs the board testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module board_tb -f list.f -o board_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/board_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0

/* tb/board_tb.sv */
`timescale 1ns/1ps

module board_tb;
    import board_pkg::*;

    localparam int max_cycles = 4000;   // About twice the stimulus length

    logic clk_sys = 1'b0;
    logic rst, downloading, rst_req, key_pause, key_reset, key_service;
    logic pxl_cen, lhbl, lvbl, hs, vs;
    logic [1:0] key_coin, key_start;
    status_t status;
    joy_board_t board_joystick1, board_joystick2;
    gfx_t key_gfx;
    color_t game_r, game_g, game_b;
    logic game_rst, dip_flip, dip_pause, dip_test, game_service, game_pause;
    logic vid_hs, vid_vs, vid_de;
    logic [1:0] game_coin, game_start;
    joy_game_t game_joystick1, game_joystick2;
    gfx_t gfx_en;
    rgb8_t vid_r, vid_g, vid_b;

    logic [31:0] lfsr = 32'h5a7a_e7cc;
    int cycle_count = 0;
    logic [2:0] warm_cnt;
    logic warm;
    // Input history, d1 is last edge and d2 the one before
    joy_board_t j1_d1, j1_d2, j2_d1, j2_d2;
    logic rot_d1, rot_d2, pause_d1, kres_d1, kres_d2, rst_d1, flip_m, flip_d;
    logic [1:0] ks_d1, kc_d1;
    logic svc_d1;
    gfx_t gfx_d1, gfx_m;
    logic pause_m, dip_m, rst_m, de_m, test_m, hs_m, vs_m;
    logic [4:0] age;
    logic trig;
    rgb8_t r_m, g_m, b_m;
    joy_game_t exp_joy1, exp_joy2;
    logic [1:0] exp_start, exp_coin;

    board_top dut (.*);

    always #4 clk_sys = ~clk_sys;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Low ten bits, directions swapped for a rotated screen, game polarity
    function automatic joy_game_t map_joy(input joy_board_t j, input logic rot);
        joy_game_t d;
        d = j[9:0];
        if (rot) d[3:0] = {j[0], j[1], j[3], j[2]};
        return active_low_inputs ? ~d : d;
    endfunction

    function automatic logic [1:0] polarity(input logic [1:0] v);
        return active_low_inputs ? ~v : v;
    endfunction

    task automatic stop_run(input string why);
        $display("%s at %0t", why, $time);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic step();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic wait_release(input string what);
        int n;
        n = 0;
        repeat (3) step();
        while (game_rst !== 1'b0) begin
            step();
            n++;
            if (n > 100) stop_run({"game_rst never released after ", what});
        end
        repeat (4) step();
    endtask

    assign exp_joy1  = map_joy(j1_d2, rot_d2);
    assign exp_joy2  = map_joy(j2_d2, rot_d2);
    assign exp_start = polarity({j1_d2[7] | j2_d2[7], j1_d2[6] | j2_d2[6]} | ks_d1);
    assign exp_coin  = polarity({j2_d2[8], j1_d2[8]} | kc_d1);
    assign warm      = warm_cnt == 3'd4;
    // Trigger as seen by the reset sequencer on this edge
    assign trig = rst | downloading | rst_req | (kres_d1 & ~kres_d2 & ~rst_d1) | (flip_m != flip_d);

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) stop_run("Timeout, stimulus did not finish");
        warm_cnt <= rst ? 3'd0 : (warm ? warm_cnt : warm_cnt + 3'd1);
        j1_d1 <= board_joystick1;
        j1_d2 <= j1_d1;
        j2_d1 <= board_joystick2;
        j2_d2 <= j2_d1;
        rot_d1 <= rst ? 1'b0 : status[st_rotate_bit];
        rot_d2 <= rot_d1;
        ks_d1 <= key_start;
        kc_d1 <= key_coin;
        svc_d1 <= key_service;
        pause_d1 <= key_pause;
        gfx_d1 <= key_gfx;
        kres_d1 <= key_reset;
        kres_d2 <= kres_d1;
        rst_d1 <= rst;
        flip_m <= rst ? 1'b0 : status[st_flip_bit];
        flip_d <= flip_m;
        test_m <= rst ? 1'b0 : status[st_test_bit];
        dip_m <= rst ? 1'b1 : ~(status[st_pause_bit] | pause_m);
        if (rst) begin
            pause_m <= 1'b0;
            gfx_m <= '1;
        end else begin
            gfx_m <= gfx_m ^ (key_gfx & ~gfx_d1);
            if ((key_pause & ~pause_d1) | ((j1_d1[9] | j2_d1[9]) & ~(j1_d2[9] | j2_d2[9])))
                pause_m <= ~pause_m;
        end
        age <= trig ? 5'd0 : (age == 5'd31 ? age : age + 5'd1);
        rst_m <= trig || (age < 5'(game_rst_cycles - 1));
        if (pxl_cen) begin
            r_m <= {game_r, game_r};
            g_m <= {game_g, game_g};
            b_m <= {game_b, game_b};
        end
        de_m <= rst ? 1'b0 : (pxl_cen ? lhbl & lvbl : de_m);
        hs_m <= rst ? 1'b0 : (pxl_cen ? hs : hs_m);
        vs_m <= rst ? 1'b0 : (pxl_cen ? vs : vs_m);
    end

    a_joy1 : assert property (@(posedge clk_sys) disable iff (rst)
        warm |-> game_joystick1 == exp_joy1)
        else value_error("game_joystick1", 32'($sampled(game_joystick1)), 32'($sampled(exp_joy1)));
    a_joy2 : assert property (@(posedge clk_sys) disable iff (rst)
        warm |-> game_joystick2 == exp_joy2)
        else value_error("game_joystick2", 32'($sampled(game_joystick2)), 32'($sampled(exp_joy2)));
    a_start : assert property (@(posedge clk_sys) disable iff (rst)
        warm |-> game_start == exp_start)
        else value_error("game_start", 32'($sampled(game_start)), 32'($sampled(exp_start)));
    a_coin : assert property (@(posedge clk_sys) disable iff (rst)
        warm |-> game_coin == exp_coin)
        else value_error("game_coin", 32'($sampled(game_coin)), 32'($sampled(exp_coin)));
    a_service : assert property (@(posedge clk_sys) disable iff (rst)
        warm |-> game_service == ~svc_d1)
        else value_error("game_service", 32'($sampled(game_service)), 32'($sampled(~svc_d1)));
    a_pause : assert property (@(posedge clk_sys) disable iff (rst)
        warm |-> game_pause == pause_m)
        else value_error("game_pause", 32'($sampled(game_pause)), 32'($sampled(pause_m)));
    a_dip_pause : assert property (@(posedge clk_sys) warm |-> dip_pause == dip_m)
        else value_error("dip_pause", 32'($sampled(dip_pause)), 32'($sampled(dip_m)));
    a_dip_flip : assert property (@(posedge clk_sys) warm |-> dip_flip == flip_m)
        else value_error("dip_flip", 32'($sampled(dip_flip)), 32'($sampled(flip_m)));
    a_dip_test : assert property (@(posedge clk_sys) warm |-> dip_test == test_m)
        else value_error("dip_test", 32'($sampled(dip_test)), 32'($sampled(test_m)));
    a_gfx : assert property (@(posedge clk_sys) warm |-> gfx_en == gfx_m)
        else value_error("gfx_en", 32'($sampled(gfx_en)), 32'($sampled(gfx_m)));
    a_game_rst : assert property (@(posedge clk_sys) warm |-> game_rst == rst_m)
        else value_error("game_rst", 32'($sampled(game_rst)), 32'($sampled(rst_m)));
    a_vid_r : assert property (@(posedge clk_sys) warm |-> vid_r == r_m)
        else value_error("vid_r", 32'($sampled(vid_r)), 32'($sampled(r_m)));
    a_vid_g : assert property (@(posedge clk_sys) warm |-> vid_g == g_m)
        else value_error("vid_g", 32'($sampled(vid_g)), 32'($sampled(g_m)));
    a_vid_b : assert property (@(posedge clk_sys) warm |-> vid_b == b_m)
        else value_error("vid_b", 32'($sampled(vid_b)), 32'($sampled(b_m)));
    a_vid_de : assert property (@(posedge clk_sys) warm |-> vid_de == de_m)
        else value_error("vid_de", 32'($sampled(vid_de)), 32'($sampled(de_m)));
    a_vid_hs : assert property (@(posedge clk_sys) warm |-> vid_hs == hs_m)
        else value_error("vid_hs", 32'($sampled(vid_hs)), 32'($sampled(hs_m)));
    a_vid_vs : assert property (@(posedge clk_sys) warm |-> vid_vs == vs_m)
        else value_error("vid_vs", 32'($sampled(vid_vs)), 32'($sampled(vs_m)));

    initial begin
        {rst, downloading, rst_req, key_pause, key_reset, key_service} = 6'b100000;
        {lhbl, lvbl, hs, vs} = '0;
        pxl_cen = 1'b1;     // Loads the video registers during reset
        {key_coin, key_start, key_gfx, status} = '0;
        {board_joystick1, board_joystick2, game_r, game_g, game_b} = '0;
        repeat (8) @(posedge clk_sys);
        #1 rst = 1'b0;
        repeat (4) step();
        // Joystick mapping, rotation flips every 64 cycles
        for (int i = 0; i < 600; i++) begin
            board_joystick1 = joy_board_t'(take_bits(16));
            board_joystick2 = joy_board_t'(take_bits(16));
            key_coin = 2'(take_bits(2));
            key_start = 2'(take_bits(2));
            key_service = take_bits(1) == 32'd1;
            status[st_rotate_bit] = i[6];
            status[st_test_bit] = i[5];     // Test switch every 32 cycles
            step();
        end
        {board_joystick1, board_joystick2, key_coin, key_start, key_service} = '0;
        // Pause from keys held several cycles, the joystick and the OSD
        for (int i = 0; i < 200; i++) begin
            if (i % 8 == 0) key_pause = take_bits(1) == 32'd1;
            if (i % 16 == 0) board_joystick2[9] = take_bits(2) == 32'd0;
            status[st_pause_bit] = i >= 120 && i < 150;
            step();
        end
        key_pause = 1'b0;
        board_joystick2 = '0;
        // Graphics layer toggles
        for (int i = 0; i < 200; i++) begin
            if (i % 4 == 0) key_gfx = gfx_t'(take_bits(gfx_layers));
            step();
        end
        // Soft reset from the keyboard
        for (int i = 0; i < 4; i++) begin
            key_reset = 1'b1;
            repeat (2) step();
            key_reset = 1'b0;
            wait_release("key_reset");
        end
        // Flip change, reset request and ROM download
        for (int i = 0; i < 2; i++) begin
            status[st_flip_bit] = ~status[st_flip_bit];
            wait_release("flip change");
        end
        rst_req = 1'b1;
        step();
        rst_req = 1'b0;
        wait_release("rst_req");
        downloading = 1'b1;
        repeat (5) step();
        downloading = 1'b0;
        wait_release("downloading");
        // Video with a mostly running pixel enable
        for (int i = 0; i < 400; i++) begin
            game_r = color_t'(take_bits(color_w));
            game_g = color_t'(take_bits(color_w));
            game_b = color_t'(take_bits(color_w));
            {lhbl, lvbl, hs, vs} = 4'(take_bits(4));
            pxl_cen = take_bits(2) != 32'd0;
            step();
        end
        repeat (4) step();
        $display("All checks passed");
        $finish;
    end

endmodule
